// File: rtl/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths

`define DATA_WIDTH    32      // one data word
`define ADDR_WIDTH    18      // pc counts words, not bytes

//////////////////////////////////////////////////////////////////////
// instruction fields

`define REG_IDX_WIDTH 5
`define OPCODE_WIDTH  6       // opcode and funct
`define IMM_WIDTH     16

`define LINK_REG      31      // jal and jalr destination

`endif

// File: rtl/decoder_pkg.sv
`default_nettype none

`include "decoder_settings.svh"

package decoder_pkg;

    typedef logic [`DATA_WIDTH-1:0]    data_t;
    typedef logic [`ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [`OPCODE_WIDTH-1:0]  opcode_t;
    typedef logic [`IMM_WIDTH-1:0]     imm16_t;

    // NONE stays zero so an illegal word decodes to all zeros
    typedef enum logic [5:0] {
        KIND_NONE,
        KIND_NOP,
        KIND_SLL, KIND_SRL, KIND_SRA,
        KIND_SLLV, KIND_SRLV, KIND_SRAV,
        KIND_JR, KIND_JALR, KIND_J, KIND_JAL,
        KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU,
        KIND_AND, KIND_OR, KIND_XOR, KIND_NOR,
        KIND_SLT, KIND_SLTU,
        KIND_BLTZ, KIND_BGEZ, KIND_BEQ, KIND_BNE, KIND_BLEZ, KIND_BGTZ,
        KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU,
        KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI,
        KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
        KIND_SB, KIND_SH, KIND_SW
    } inst_kind_e;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LT, ALU_LTU,
        ALU_EQ, ALU_NE, ALU_GE, ALU_GT, ALU_LE,
        ALU_LU                              // load upper
    } alu_op_e;

    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_IMM,                           // target from the index field
        JUMP_REG                            // target from rs
    } jump_e;

    typedef struct packed {
        logic       rs_enable;
        reg_idx_t   rs_addr;
        logic       rt_enable;
        reg_idx_t   rt_addr;
        logic       wb_reg;
        reg_idx_t   rd_addr;
        data_t      imm;
        addr_t      addr;                   // branch or jump target
        inst_kind_e kind;
        alu_op_e    alu_op;
        logic       b_imm;                  // operand b is imm, not rt
        logic       wb_mem;                 // write back from memory
    } decode_t;

    typedef struct packed {
        logic  mem_enable;
        jump_e jump;
        logic  branch;
        logic  illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// File: rtl/target_calc.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module target_calc (
    input  decoder_pkg::addr_t pc,
    input  decoder_pkg::data_t raw_inst,
    output decoder_pkg::addr_t branch_target,
    output decoder_pkg::addr_t jump_target,
    output decoder_pkg::addr_t link_value
);

    decoder_pkg::imm16_t offset;
    decoder_pkg::addr_t  offset_sext;

    assign offset      = raw_inst[15:0];
    assign offset_sext = {{(`ADDR_WIDTH-`IMM_WIDTH){offset[`IMM_WIDTH-1]}}, offset};

    // word addresses, so the delay slot is pc + 1
    assign branch_target = pc + decoder_pkg::addr_t'(1) + offset_sext;
    assign jump_target   = raw_inst[`ADDR_WIDTH-1:0];   // low bits of the 26-bit index
    assign link_value    = pc + decoder_pkg::addr_t'(2);  // skip the delay slot

endmodule

`default_nettype wire

// File: rtl/special_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module special_decoder (
    input  decoder_pkg::data_t   raw_inst,
    input  decoder_pkg::addr_t   link_value,
    output decoder_pkg::decode_t dec,
    output logic                 illegal
);

    decoder_pkg::reg_idx_t   rs;
    decoder_pkg::reg_idx_t   rt;
    decoder_pkg::reg_idx_t   rd;
    logic [4:0]              shamt;
    decoder_pkg::opcode_t    funct;
    decoder_pkg::inst_kind_e kind;

    assign rs    = raw_inst[25:21];
    assign rt    = raw_inst[20:16];
    assign rd    = raw_inst[15:11];
    assign shamt = raw_inst[10:6];
    assign funct = raw_inst[5:0];

    always_comb begin
        case (funct)
            6'b000000: kind = (rt == '0 && rd == '0 && shamt == '0) ?
                              decoder_pkg::KIND_NOP : decoder_pkg::KIND_SLL;
            6'b000010: kind = decoder_pkg::KIND_SRL;
            6'b000011: kind = decoder_pkg::KIND_SRA;
            6'b000100: kind = decoder_pkg::KIND_SLLV;
            6'b000110: kind = decoder_pkg::KIND_SRLV;
            6'b000111: kind = decoder_pkg::KIND_SRAV;
            6'b001000: kind = decoder_pkg::KIND_JR;
            6'b001001: kind = decoder_pkg::KIND_JALR;
            6'b100000: kind = decoder_pkg::KIND_ADD;
            6'b100001: kind = decoder_pkg::KIND_ADDU;
            6'b100010: kind = decoder_pkg::KIND_SUB;
            6'b100011: kind = decoder_pkg::KIND_SUBU;
            6'b100100: kind = decoder_pkg::KIND_AND;
            6'b100101: kind = decoder_pkg::KIND_OR;
            6'b100110: kind = decoder_pkg::KIND_XOR;
            6'b100111: kind = decoder_pkg::KIND_NOR;
            6'b101010: kind = decoder_pkg::KIND_SLT;
            6'b101011: kind = decoder_pkg::KIND_SLTU;
            default:   kind = decoder_pkg::KIND_NONE;
        endcase
    end

    assign illegal = (kind == decoder_pkg::KIND_NONE);

    always_comb begin
        dec      = '0;
        dec.kind = kind;
        case (kind)
            decoder_pkg::KIND_SLL, decoder_pkg::KIND_SRL, decoder_pkg::KIND_SRA: begin
                dec.rs_enable = 1'b1;
                dec.rs_addr   = rt;                 // shifted value sits in rt
                dec.wb_reg    = 1'b1;
                dec.rd_addr   = rd;
                dec.imm       = decoder_pkg::data_t'(shamt);
                dec.b_imm     = 1'b1;
            end
            decoder_pkg::KIND_SLLV, decoder_pkg::KIND_SRLV, decoder_pkg::KIND_SRAV: begin
                dec.rs_enable = 1'b1;
                dec.rs_addr   = rt;
                dec.rt_enable = 1'b1;
                dec.rt_addr   = rs;                 // amount from rs
                dec.wb_reg    = 1'b1;
                dec.rd_addr   = rd;
            end
            decoder_pkg::KIND_JR: begin
                dec.rs_enable = 1'b1;
                dec.rs_addr   = rs;
            end
            decoder_pkg::KIND_JALR: begin
                dec.rs_enable = 1'b1;
                dec.rs_addr   = rs;
                dec.wb_reg    = 1'b1;
                dec.rd_addr   = decoder_pkg::reg_idx_t'(`LINK_REG);
                dec.imm       = decoder_pkg::data_t'(link_value);
                dec.b_imm     = 1'b1;
            end
            decoder_pkg::KIND_NOP, decoder_pkg::KIND_NONE: ;
            default: begin                          // three-operand alu
                dec.rs_enable = 1'b1;
                dec.rs_addr   = rs;
                dec.rt_enable = 1'b1;
                dec.rt_addr   = rt;
                dec.wb_reg    = 1'b1;
                dec.rd_addr   = rd;
            end
        endcase

        case (kind)
            decoder_pkg::KIND_SLL, decoder_pkg::KIND_SLLV: dec.alu_op = decoder_pkg::ALU_SLL;
            decoder_pkg::KIND_SRL, decoder_pkg::KIND_SRLV: dec.alu_op = decoder_pkg::ALU_SRL;
            decoder_pkg::KIND_SRA, decoder_pkg::KIND_SRAV: dec.alu_op = decoder_pkg::ALU_SRA;
            decoder_pkg::KIND_JALR: dec.alu_op = decoder_pkg::ALU_ADDU;
            decoder_pkg::KIND_ADD:  dec.alu_op = decoder_pkg::ALU_ADD;
            decoder_pkg::KIND_ADDU: dec.alu_op = decoder_pkg::ALU_ADDU;
            decoder_pkg::KIND_SUB:  dec.alu_op = decoder_pkg::ALU_SUB;
            decoder_pkg::KIND_SUBU: dec.alu_op = decoder_pkg::ALU_SUBU;
            decoder_pkg::KIND_AND:  dec.alu_op = decoder_pkg::ALU_AND;
            decoder_pkg::KIND_OR:   dec.alu_op = decoder_pkg::ALU_OR;
            decoder_pkg::KIND_XOR:  dec.alu_op = decoder_pkg::ALU_XOR;
            decoder_pkg::KIND_NOR:  dec.alu_op = decoder_pkg::ALU_NOR;
            decoder_pkg::KIND_SLT:  dec.alu_op = decoder_pkg::ALU_LT;
            decoder_pkg::KIND_SLTU: dec.alu_op = decoder_pkg::ALU_LTU;
            default:                dec.alu_op = decoder_pkg::ALU_NOP;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module opcode_decoder (
    input  decoder_pkg::data_t   raw_inst,
    input  decoder_pkg::addr_t   branch_target,
    input  decoder_pkg::addr_t   jump_target,
    input  decoder_pkg::addr_t   link_value,
    output decoder_pkg::decode_t dec,
    output logic                 illegal
);

    decoder_pkg::opcode_t    op;
    decoder_pkg::reg_idx_t   rs;
    decoder_pkg::reg_idx_t   rt;
    decoder_pkg::imm16_t     imm;
    decoder_pkg::data_t      imm_sext;
    decoder_pkg::data_t      imm_zext;
    decoder_pkg::inst_kind_e kind;
    decoder_pkg::decode_t    op_dec;
    decoder_pkg::decode_t    sp_dec;
    logic                    sp_illegal;

    assign op       = raw_inst[31:26];
    assign rs       = raw_inst[25:21];
    assign rt       = raw_inst[20:16];
    assign imm      = raw_inst[15:0];
    assign imm_sext = {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
    assign imm_zext = decoder_pkg::data_t'(imm);

    special_decoder u_special_decoder (
        .raw_inst   (raw_inst),
        .link_value (link_value),
        .dec        (sp_dec),
        .illegal    (sp_illegal)
    );

    always_comb begin
        case (op)
            6'b000001: kind = (rt == 5'd0) ? decoder_pkg::KIND_BLTZ :
                              (rt == 5'd1) ? decoder_pkg::KIND_BGEZ : decoder_pkg::KIND_NONE;
            6'b000010: kind = decoder_pkg::KIND_J;
            6'b000011: kind = decoder_pkg::KIND_JAL;
            6'b000100: kind = decoder_pkg::KIND_BEQ;
            6'b000101: kind = decoder_pkg::KIND_BNE;
            6'b000110: kind = decoder_pkg::KIND_BLEZ;
            6'b000111: kind = decoder_pkg::KIND_BGTZ;
            6'b001000: kind = decoder_pkg::KIND_ADDI;
            6'b001001: kind = decoder_pkg::KIND_ADDIU;
            6'b001010: kind = decoder_pkg::KIND_SLTI;
            6'b001011: kind = decoder_pkg::KIND_SLTIU;
            6'b001100: kind = decoder_pkg::KIND_ANDI;
            6'b001101: kind = decoder_pkg::KIND_ORI;
            6'b001110: kind = decoder_pkg::KIND_XORI;
            6'b001111: kind = decoder_pkg::KIND_LUI;
            6'b100000: kind = decoder_pkg::KIND_LB;
            6'b100001: kind = decoder_pkg::KIND_LH;
            6'b100011: kind = decoder_pkg::KIND_LW;
            6'b100100: kind = decoder_pkg::KIND_LBU;
            6'b100101: kind = decoder_pkg::KIND_LHU;
            6'b101000: kind = decoder_pkg::KIND_SB;
            6'b101001: kind = decoder_pkg::KIND_SH;
            6'b101011: kind = decoder_pkg::KIND_SW;
            default:   kind = decoder_pkg::KIND_NONE;  // special handled below
        endcase
    end

    always_comb begin
        op_dec      = '0;
        op_dec.kind = kind;
        case (kind)
            decoder_pkg::KIND_BLTZ, decoder_pkg::KIND_BGEZ,
            decoder_pkg::KIND_BLEZ, decoder_pkg::KIND_BGTZ: begin
                op_dec.rs_enable = 1'b1;
                op_dec.rs_addr   = rs;
                op_dec.addr      = branch_target;
            end
            decoder_pkg::KIND_BEQ, decoder_pkg::KIND_BNE: begin
                op_dec.rs_enable = 1'b1;
                op_dec.rs_addr   = rs;
                op_dec.rt_enable = 1'b1;
                op_dec.rt_addr   = rt;
                op_dec.addr      = branch_target;
            end
            decoder_pkg::KIND_J: op_dec.addr = jump_target;
            decoder_pkg::KIND_JAL: begin
                op_dec.addr    = jump_target;
                op_dec.wb_reg  = 1'b1;
                op_dec.rd_addr = decoder_pkg::reg_idx_t'(`LINK_REG);
                op_dec.imm     = decoder_pkg::data_t'(link_value);
                op_dec.b_imm   = 1'b1;
            end
            decoder_pkg::KIND_SB, decoder_pkg::KIND_SH, decoder_pkg::KIND_SW: begin
                op_dec.rs_enable = 1'b1;
                op_dec.rs_addr   = rs;
                op_dec.rt_enable = 1'b1;                // store data
                op_dec.rt_addr   = rt;
                op_dec.imm       = imm_sext;
                op_dec.b_imm     = 1'b1;
            end
            decoder_pkg::KIND_NONE: ;
            default: begin                              // alu immediate, lui, loads
                op_dec.rs_enable = (kind != decoder_pkg::KIND_LUI);
                op_dec.rs_addr   = (kind != decoder_pkg::KIND_LUI) ? rs : '0;
                op_dec.wb_reg    = 1'b1;
                op_dec.rd_addr   = rt;
                op_dec.b_imm     = 1'b1;
                op_dec.wb_mem    = (kind inside {decoder_pkg::KIND_LB, decoder_pkg::KIND_LH,
                    decoder_pkg::KIND_LW, decoder_pkg::KIND_LBU, decoder_pkg::KIND_LHU});
                op_dec.imm       = (kind inside {decoder_pkg::KIND_ANDI, decoder_pkg::KIND_ORI,
                    decoder_pkg::KIND_XORI}) ? imm_zext : imm_sext;
            end
        endcase

        case (kind)
            decoder_pkg::KIND_BLTZ, decoder_pkg::KIND_SLTI: op_dec.alu_op = decoder_pkg::ALU_LT;
            decoder_pkg::KIND_BGEZ:  op_dec.alu_op = decoder_pkg::ALU_GE;
            decoder_pkg::KIND_BLEZ:  op_dec.alu_op = decoder_pkg::ALU_LE;
            decoder_pkg::KIND_BGTZ:  op_dec.alu_op = decoder_pkg::ALU_GT;
            decoder_pkg::KIND_BEQ:   op_dec.alu_op = decoder_pkg::ALU_EQ;
            decoder_pkg::KIND_BNE:   op_dec.alu_op = decoder_pkg::ALU_NE;
            decoder_pkg::KIND_J, decoder_pkg::KIND_JAL,
            decoder_pkg::KIND_ADDIU: op_dec.alu_op = decoder_pkg::ALU_ADDU;
            decoder_pkg::KIND_SLTIU: op_dec.alu_op = decoder_pkg::ALU_LTU;
            decoder_pkg::KIND_ANDI:  op_dec.alu_op = decoder_pkg::ALU_AND;
            decoder_pkg::KIND_ORI:   op_dec.alu_op = decoder_pkg::ALU_OR;
            decoder_pkg::KIND_XORI:  op_dec.alu_op = decoder_pkg::ALU_XOR;
            decoder_pkg::KIND_LUI:   op_dec.alu_op = decoder_pkg::ALU_LU;
            decoder_pkg::KIND_NONE:  op_dec.alu_op = decoder_pkg::ALU_NOP;
            default:                 op_dec.alu_op = decoder_pkg::ALU_ADD;  // addi, address calc
        endcase
    end

    // opcode zero is the SPECIAL group
    assign dec     = (op == '0) ? sp_dec : op_dec;
    assign illegal = (op == '0) ? sp_illegal : (kind == decoder_pkg::KIND_NONE);

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 in_valid,
    input  decoder_pkg::addr_t   pc,
    input  decoder_pkg::data_t   raw_inst,
    output logic                 out_valid,
    output decoder_pkg::decode_t dec,
    output decoder_pkg::ctrl_t   ctrl
);

    decoder_pkg::addr_t   branch_target;
    decoder_pkg::addr_t   jump_target;
    decoder_pkg::addr_t   link_value;
    decoder_pkg::decode_t dec_next;
    decoder_pkg::ctrl_t   ctrl_next;
    logic                 illegal_next;

    target_calc u_target_calc (
        .pc            (pc),
        .raw_inst      (raw_inst),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .link_value    (link_value)
    );

    opcode_decoder u_opcode_decoder (
        .raw_inst      (raw_inst),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .link_value    (link_value),
        .dec           (dec_next),
        .illegal       (illegal_next)
    );

    //////////////////////////////////////////////////////////////////////
    // control flags from the decoded kind

    always_comb begin
        ctrl_next         = '0;
        ctrl_next.illegal = illegal_next;
        case (dec_next.kind)
            decoder_pkg::KIND_LB, decoder_pkg::KIND_LH, decoder_pkg::KIND_LW,
            decoder_pkg::KIND_LBU, decoder_pkg::KIND_LHU,
            decoder_pkg::KIND_SB, decoder_pkg::KIND_SH, decoder_pkg::KIND_SW:
                ctrl_next.mem_enable = 1'b1;
            decoder_pkg::KIND_JR, decoder_pkg::KIND_JALR: begin
                ctrl_next.jump   = decoder_pkg::JUMP_REG;
                ctrl_next.branch = 1'b1;
            end
            decoder_pkg::KIND_J, decoder_pkg::KIND_JAL: begin
                ctrl_next.jump   = decoder_pkg::JUMP_IMM;
                ctrl_next.branch = 1'b1;
            end
            decoder_pkg::KIND_BLTZ, decoder_pkg::KIND_BGEZ, decoder_pkg::KIND_BEQ,
            decoder_pkg::KIND_BNE, decoder_pkg::KIND_BLEZ, decoder_pkg::KIND_BGTZ:
                ctrl_next.branch = 1'b1;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            dec       <= '0;
            ctrl      <= '0;
        end else if (!stall) begin
            out_valid <= in_valid;
            if (in_valid) begin         // bubble keeps the last record
                dec  <= dec_next;
                ctrl <= ctrl_next;
            end
        end
    end

    illegal_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && ctrl.illegal |-> dec == '0)
        else $error("illegal word left a nonzero decode record");

    jump_is_branch: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.jump != decoder_pkg::JUMP_NONE |-> ctrl.branch)
        else $error("jump without branch flag");

    mem_not_branch: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_enable && ctrl.branch))
        else $error("memory access flagged as branch");

endmodule

`default_nettype wire

// File: test/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// kept encodings for the generator

localparam logic [18*6-1:0] kept_functs = {
    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h20,
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
localparam logic [23*6-1:0] kept_ops = {
    6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
    6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};

// mostly a kept encoding with random fields, otherwise any 32 bits
function automatic decoder_pkg::data_t make_inst(
    input logic [31:0] r0,
    input logic [31:0] r1,
    input int          share
);
    decoder_pkg::data_t w;
    w = r1;
    if (int'(r0[3:0]) >= share) begin
        if (r0[4]) begin
            w[31:26] = 6'h00;
            w[5:0]   = kept_functs[(r0[15:8] % 18) * 6 +: 6];
            if (r0[7:5] == 3'd0) begin
                w[20:6] = '0;                       // gives nop for funct zero
            end
        end else begin
            w[31:26] = kept_ops[(r0[15:8] % 23) * 6 +: 6];
            if (w[31:26] == 6'h01 && r0[6]) begin
                w[20:17] = '0;                      // bltz or bgez
            end
        end
    end
    return w;
endfunction

// en is {rs_enable, rt_enable, wb_reg}
function automatic decoder_pkg::decode_t with_regs(
    input decoder_pkg::decode_t  d,
    input logic [2:0]            en,
    input decoder_pkg::reg_idx_t rs,
    input decoder_pkg::reg_idx_t rt,
    input decoder_pkg::reg_idx_t rd
);
    decoder_pkg::decode_t r;
    r           = d;
    r.rs_enable = en[2];
    r.rs_addr   = rs;
    r.rt_enable = en[1];
    r.rt_addr   = rt;
    r.wb_reg    = en[0];
    r.rd_addr   = rd;
    return r;
endfunction

//////////////////////////////////////////////////////////////////////
// expected decode record and control flags of one word

task automatic predict(
    input  decoder_pkg::data_t   w,
    input  decoder_pkg::addr_t   pc,
    output decoder_pkg::decode_t d,
    output decoder_pkg::ctrl_t   c
);
    decoder_pkg::opcode_t  op;
    decoder_pkg::opcode_t  fn;
    decoder_pkg::reg_idx_t rs;
    decoder_pkg::reg_idx_t rt;
    decoder_pkg::reg_idx_t rd;
    decoder_pkg::reg_idx_t lr;
    decoder_pkg::data_t    sext;
    decoder_pkg::data_t    link;
    decoder_pkg::addr_t    bt;
    logic [1:0]            sh;
    logic                  lui;
    logic                  bad;
    op   = w[31:26];
    fn   = w[5:0];
    rs   = w[25:21];
    rt   = w[20:16];
    rd   = w[15:11];
    lr   = decoder_pkg::reg_idx_t'(`LINK_REG);
    sext = {{16{w[15]}}, w[15:0]};
    link = decoder_pkg::data_t'(decoder_pkg::addr_t'(pc + 18'd2));  // wraps in the word space
    bt   = pc + 18'd1 + sext[17:0];
    sh   = {1'b0, w[1]} + {1'b0, w[0]};     // funct low bits 0, 2, 3 pick sll, srl, sra
    lui  = (op == 6'h0f);
    d    = '0;
    c    = '0;
    bad  = 1'b0;
    if (op == 6'h00) begin
        if (fn == 6'h00 && w[20:6] == '0) begin
            d.kind = decoder_pkg::KIND_NOP;
        end else if (fn inside {6'h00, 6'h02, 6'h03}) begin
            d        = with_regs(d, 3'b101, rt, 5'd0, rd);
            d.kind   = decoder_pkg::inst_kind_e'(decoder_pkg::KIND_SLL + sh);
            d.alu_op = decoder_pkg::alu_op_e'(decoder_pkg::ALU_SLL + sh);
            d.imm    = decoder_pkg::data_t'(w[10:6]);
            d.b_imm  = 1'b1;
        end else if (fn inside {6'h04, 6'h06, 6'h07}) begin
            d        = with_regs(d, 3'b111, rt, rs, rd);
            d.kind   = decoder_pkg::inst_kind_e'(decoder_pkg::KIND_SLLV + sh);
            d.alu_op = decoder_pkg::alu_op_e'(decoder_pkg::ALU_SLL + sh);
        end else if (fn == 6'h08 || fn == 6'h09) begin
            d        = with_regs(d, {2'b10, fn[0]}, rs, 5'd0, fn[0] ? lr : 5'd0);
            d.kind   = fn[0] ? decoder_pkg::KIND_JALR : decoder_pkg::KIND_JR;
            d.alu_op = fn[0] ? decoder_pkg::ALU_ADDU : decoder_pkg::ALU_NOP;
            d.imm    = fn[0] ? link : '0;
            d.b_imm  = fn[0];
            c.jump   = decoder_pkg::JUMP_REG;
        end else if (fn[5:3] == 3'b100 || fn == 6'h2a || fn == 6'h2b) begin
            d = with_regs(d, 3'b111, rs, rt, rd);
            if (fn[3]) begin
                d.kind   = decoder_pkg::inst_kind_e'(decoder_pkg::KIND_SLT + fn[0]);
                d.alu_op = decoder_pkg::alu_op_e'(decoder_pkg::ALU_LT + fn[0]);
            end else begin                  // funct order follows the enum order
                d.kind   = decoder_pkg::inst_kind_e'(decoder_pkg::KIND_ADD + fn[2:0]);
                d.alu_op = decoder_pkg::alu_op_e'(decoder_pkg::ALU_ADD + fn[2:0]);
            end
        end else begin
            bad = 1'b1;
        end
    end else begin
        case (op)
            6'h01: begin
                bad      = (rt[4:1] != 4'd0);
                d        = with_regs(d, 3'b100, rs, 5'd0, 5'd0);
                d.kind   = rt[0] ? decoder_pkg::KIND_BGEZ : decoder_pkg::KIND_BLTZ;
                d.alu_op = rt[0] ? decoder_pkg::ALU_GE : decoder_pkg::ALU_LT;
                d.addr   = bt;
                c.branch = 1'b1;
            end
            6'h02, 6'h03: begin
                d        = with_regs(d, {2'b00, op[0]}, 5'd0, 5'd0, op[0] ? lr : 5'd0);
                d.kind   = op[0] ? decoder_pkg::KIND_JAL : decoder_pkg::KIND_J;
                d.alu_op = decoder_pkg::ALU_ADDU;
                d.addr   = decoder_pkg::addr_t'(w[25:0]);
                d.imm    = op[0] ? link : '0;
                d.b_imm  = op[0];
                c.jump   = decoder_pkg::JUMP_IMM;
            end
            6'h04, 6'h05: begin
                d        = with_regs(d, 3'b110, rs, rt, 5'd0);
                d.kind   = op[0] ? decoder_pkg::KIND_BNE : decoder_pkg::KIND_BEQ;
                d.alu_op = op[0] ? decoder_pkg::ALU_NE : decoder_pkg::ALU_EQ;
                d.addr   = bt;
                c.branch = 1'b1;
            end
            6'h06, 6'h07: begin
                d        = with_regs(d, 3'b100, rs, 5'd0, 5'd0);
                d.kind   = op[0] ? decoder_pkg::KIND_BGTZ : decoder_pkg::KIND_BLEZ;
                d.alu_op = op[0] ? decoder_pkg::ALU_GT : decoder_pkg::ALU_LE;
                d.addr   = bt;
                c.branch = 1'b1;
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                d       = with_regs(d, {!lui, 2'b01}, lui ? 5'd0 : rs, 5'd0, rt);
                d.kind  = decoder_pkg::inst_kind_e'(decoder_pkg::KIND_ADDI + op[2:0]);
                d.imm   = (op[2] && !lui) ? decoder_pkg::data_t'(w[15:0]) : sext;
                d.b_imm = 1'b1;
                case (op[2:1])
                    2'b00:   d.alu_op = op[0] ? decoder_pkg::ALU_ADDU : decoder_pkg::ALU_ADD;
                    2'b01:   d.alu_op = op[0] ? decoder_pkg::ALU_LTU : decoder_pkg::ALU_LT;
                    default: d.alu_op = lui ? decoder_pkg::ALU_LU :
                                 decoder_pkg::alu_op_e'(decoder_pkg::ALU_AND + op[1:0]);
                endcase
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                d            = with_regs(d, 3'b101, rs, 5'd0, rt);
                d.kind       = (op[2:0] == 3'd0) ? decoder_pkg::KIND_LB :
                               (op[2:0] == 3'd1) ? decoder_pkg::KIND_LH :
                               (op[2:0] == 3'd3) ? decoder_pkg::KIND_LW :
                               op[0] ? decoder_pkg::KIND_LHU : decoder_pkg::KIND_LBU;
                d.alu_op     = decoder_pkg::ALU_ADD;
                d.imm        = sext;
                d.b_imm      = 1'b1;
                d.wb_mem     = 1'b1;
                c.mem_enable = 1'b1;
            end
            6'h28, 6'h29, 6'h2b: begin
                d            = with_regs(d, 3'b110, rs, rt, 5'd0);
                d.kind       = op[1] ? decoder_pkg::KIND_SW :
                               op[0] ? decoder_pkg::KIND_SH : decoder_pkg::KIND_SB;
                d.alu_op     = decoder_pkg::ALU_ADD;
                d.imm        = sext;
                d.b_imm      = 1'b1;
                c.mem_enable = 1'b1;
            end
            default: bad = 1'b1;
        endcase
    end
    if (c.jump != decoder_pkg::JUMP_NONE) begin
        c.branch = 1'b1;
    end
    if (bad) begin
        d         = '0;
        c         = '0;
        c.illegal = 1'b1;
    end
endtask

`endif

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module tb_decode_stage;

    localparam logic [31:0] seed         = 32'd41;
    localparam int          num_vectors  = 3000;
    localparam int          random_share = 3;         // out of 16
    localparam int          timeout_ns   = (num_vectors + 10) * 4 + 1000;

    logic                 clk;
    logic                 rst_n;
    logic                 stall;
    logic                 in_valid;
    decoder_pkg::addr_t   pc;
    decoder_pkg::data_t   raw_inst;
    logic                 out_valid;
    decoder_pkg::decode_t dec;
    decoder_pkg::ctrl_t   ctrl;

    logic                 exp_valid;
    decoder_pkg::decode_t exp_dec;
    decoder_pkg::ctrl_t   exp_ctrl;
    string                exp_name;
    logic [31:0]          rng;
    int                   errors;
    int                   checks;

    `include "decode_model.svh"

    decode_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .in_valid  (in_valid),
        .pc        (pc),
        .raw_inst  (raw_inst),
        .out_valid (out_valid),
        .dec       (dec),
        .ctrl      (ctrl)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_outputs();
        checks = checks + 1;
        assert (out_valid === exp_valid) else begin
            errors = errors + 1;
            $display("MISMATCH %s out_valid expected %b actual %b", exp_name, exp_valid, out_valid);
        end
        assert (dec === exp_dec) else begin
            errors = errors + 1;
            $display("MISMATCH %s dec expected %h actual %h", exp_name, exp_dec, dec);
        end
        assert (ctrl === exp_ctrl) else begin
            errors = errors + 1;
            $display("MISMATCH %s ctrl expected %b actual %b", exp_name, exp_ctrl, ctrl);
        end
    endtask

    // model takes the word at the next rising edge unless stalled
    task automatic drive_vector(input int idx);
        logic [31:0]             r0;
        logic [31:0]             r1;
        logic [31:0]             r2;
        decoder_pkg::inst_kind_e k;
        rng = xorshift(rng);
        r0  = rng;
        rng = xorshift(rng);
        r1  = rng;
        rng = xorshift(rng);
        r2  = rng;
        raw_inst = make_inst(r0, r1, random_share);
        pc       = decoder_pkg::addr_t'(r2);
        stall    = (r2[25:24] == 2'b00);            // about a quarter
        in_valid = (r2[28:26] != 3'b000);
        if (!stall) begin
            exp_valid = in_valid;
            if (in_valid) begin
                predict(raw_inst, pc, exp_dec, exp_ctrl);
                k        = exp_dec.kind;
                exp_name = $sformatf("vec%0d_%s", idx, k.name());
            end
        end
    endtask

    initial begin
        int vec;
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        in_valid  = 1'b0;
        pc        = '0;
        raw_inst  = '0;
        exp_valid = 1'b0;
        exp_dec   = '0;
        exp_ctrl  = '0;
        exp_name  = "reset";
        rng       = seed;
        errors    = 0;
        checks    = 0;
        repeat (8) @(negedge clk);
        check_outputs();
        rst_n = 1'b1;
        for (vec = 0; vec < num_vectors; vec++) begin
            @(negedge clk);
            check_outputs();
            drive_vector(vec);
        end
        @(negedge clk);
        check_outputs();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout: stimulus did not complete within %0d ns", timeout_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
+incdir+test
rtl/decoder_pkg.sv
rtl/target_calc.sv
rtl/special_decoder.sv
rtl/opcode_decoder.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the simulation log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_decode_stage \
    -Mdir obj_dir -o tb_decode_stage > build.log 2>&1 &&
./obj_dir/tb_decode_stage > sim.log 2>&1 &&
grep -qx "RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
